//--- vlog.f
+incdir+rtl
rtl/wb_ext_pkg.sv
rtl/wb_addr_ext.sv
rtl/wb_user_decoder.sv
rtl/wb_sram_slave.sv
rtl/wb_reg_bank.sv
rtl/wb_ext_top.sv
testbench/wb_ext_assertions.sv
testbench/wb_ext_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status reports pass or fail.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module wb_ext_tb \
	-Mdir obj_dir \
	-f vlog.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit $status
fi

./obj_dir/Vwb_ext_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

//--- testbench/wb_ext_tb.sv
`include "wb_ext_cfg.svh"

module wb_ext_tb;

	localparam logic [31:0] PAGE_ADR = 32'h0000_0000;

	logic        wb_clk_i;
	logic        wb_rst_i;
	logic        wbs_cyc_i;
	logic        wbs_stb_i;
	logic        wbs_we_i;
	logic [3:0]  wbs_sel_i;
	logic [31:0] wbs_adr_i;
	logic [31:0] wbs_dat_i;
	logic        wbs_ack_o;
	logic [31:0] wbs_dat_o;

	// reference model
	logic [31:0] page_model;
	logic [31:0] sram_model [16];
	logic [31:0] regs_model [3];

	integer      seed;
	logic [31:0] rnd;
	logic [31:0] data;
	logic [3:0]  idx;
	logic [3:0]  lanes;

	wb_ext_top wb_ext_top_i (
		.wb_clk_i  (wb_clk_i),
		.wb_rst_i  (wb_rst_i),
		.wbs_cyc_i (wbs_cyc_i),
		.wbs_stb_i (wbs_stb_i),
		.wbs_we_i  (wbs_we_i),
		.wbs_sel_i (wbs_sel_i),
		.wbs_adr_i (wbs_adr_i),
		.wbs_dat_i (wbs_dat_i),
		.wbs_ack_o (wbs_ack_o),
		.wbs_dat_o (wbs_dat_o)
	);

	always #50 wb_clk_i = ~wb_clk_i;

	// ******************************
	// host side helpers
	// ******************************

	task automatic abort_run(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	function automatic logic [31:0] merge_lanes(input logic [31:0] old,
			input logic [31:0] wdata, input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) res[8*b +: 8] = wdata[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic [14:0] word_ofs(input logic [3:0] w);
		return {9'h0, w, 2'b00};
	endfunction

	function automatic logic [31:0] user_adr(input logic [14:0] offset);
		return (32'h1 << `WB_EXT_PAGE_BIT) | {17'h0, offset};
	endfunction

	// one classic transfer, outputs sampled mid-cycle
	task automatic bus_cycle(input logic is_write, input logic [31:0] addr,
			input logic [3:0] sel, input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge wb_clk_i);
		#5;
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i  = is_write;
		wbs_sel_i = sel;
		wbs_adr_i = addr;
		wbs_dat_i = wdata;
		@(negedge wb_clk_i);
		while (!wbs_ack_o) begin
			waited++;
			if (waited > 20) abort_run("no ack from the DUT within 20 cycles");
			@(negedge wb_clk_i);
		end
		rdata = wbs_dat_o;
		@(posedge wb_clk_i);
		#5;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [3:0] sel,
			input logic [31:0] wdata);
		logic [31:0] unused;
		bus_cycle(1'b1, addr, sel, wdata, unused);
	endtask

	task automatic read_check(input string name, input logic [31:0] addr,
			input logic [31:0] exp);
		logic [31:0] got;
		bus_cycle(1'b0, addr, 4'hf, 32'h0, got);
		if (got !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, got);
			abort_run("read data does not match the model");
		end
	endtask

	task automatic page_write(input logic [31:0] value, input logic [3:0] sel);
		bus_write(PAGE_ADR, sel, value);
		page_model = merge_lanes(page_model, value, sel);
		read_check("page_merge", PAGE_ADR, page_model);
	endtask

	// ******************************
	// stimulus
	// ******************************

	initial begin
		wb_clk_i   = 1'b0;
		wb_rst_i   = 1'b1;
		wbs_cyc_i  = 1'b0;
		wbs_stb_i  = 1'b0;
		wbs_we_i   = 1'b0;
		wbs_sel_i  = 4'h0;
		wbs_adr_i  = 32'h0;
		wbs_dat_i  = 32'h0;
		seed       = 32'hd334_6999;
		page_model = 32'h0;
		for (int i = 0; i < 3; i++) regs_model[i] = 32'h0;
		repeat (4) @(posedge wb_clk_i);
		#5 wb_rst_i = 1'b0;

		// page register byte lanes
		read_check("page_reset", PAGE_ADR, page_model);
		page_write(32'hffff_ffff, 4'b0101);
		page_write(32'h1234_5678, 4'b1010);
		page_write(32'ha5a5_a5a5, 4'b0001);
		page_write(32'hffff_ffff, 4'b0000);	// no lanes, no change
		rnd = $random(seed);
		page_write(rnd, 4'b1100);

		// sram through its page
		page_write({`WB_SRAM_BASE, 16'h0}, 4'hf);
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			sram_model[i] = rnd;
			bus_write(user_adr(word_ofs(4'(i))), 4'hf, rnd);
		end
		repeat (40) begin
			rnd   = $random(seed);
			idx   = rnd[3:0];
			lanes = rnd[7:4];
			data  = $random(seed);
			bus_write(user_adr(word_ofs(idx)), lanes, data);
			sram_model[idx] = merge_lanes(sram_model[idx], data, lanes);
			read_check("sram_random", user_adr(word_ofs(idx)), sram_model[idx]);
		end

		// same offsets, other page: register bank
		page_write({`WB_REGS_BASE, 16'h0}, 4'hf);
		for (int i = 0; i < 3; i++) begin
			read_check("regs_reset", user_adr(word_ofs(4'(i))), 32'h0);
		end
		read_check("regs_id", user_adr(word_ofs(4'd3)), `WB_REG_ID);
		for (int i = 0; i < 3; i++) begin
			rnd = $random(seed);
			regs_model[i] = rnd;
			bus_write(user_adr(word_ofs(4'(i))), 4'hf, rnd);
			rnd   = $random(seed);
			lanes = rnd[3:0];
			data  = $random(seed);
			bus_write(user_adr(word_ofs(4'(i))), lanes, data);
			regs_model[i] = merge_lanes(regs_model[i], data, lanes);
			read_check("regs_rw", user_adr(word_ofs(4'(i))), regs_model[i]);
		end
		bus_write(user_adr(word_ofs(4'd3)), 4'hf, $random(seed));
		read_check("regs_id_write", user_adr(word_ofs(4'd3)), `WB_REG_ID);

		// unmapped page, writes must land nowhere
		page_write(32'h4000_0000, 4'hf);
		read_check("unmapped_read", user_adr(word_ofs(4'd0)), `WB_UNMAPPED_DATA);
		for (int i = 0; i < 4; i++) begin
			bus_write(user_adr(word_ofs(4'(i))), 4'hf, ~sram_model[i]);
		end
		read_check("unmapped_reread", user_adr(word_ofs(4'd1)), `WB_UNMAPPED_DATA);

		page_write({`WB_SRAM_BASE, 16'h0}, 4'hf);
		for (int i = 0; i < 16; i++) begin
			read_check("sram_kept", user_adr(word_ofs(4'(i))), sram_model[i]);
		end
		page_write({`WB_REGS_BASE, 16'h0}, 4'hf);
		for (int i = 0; i < 3; i++) begin
			read_check("regs_kept", user_adr(word_ofs(4'(i))), regs_model[i]);
		end
		read_check("regs_id_kept", user_adr(word_ofs(4'd3)), `WB_REG_ID);

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- testbench/wb_ext_assertions.sv
module wb_ext_assertions (
	input logic        wb_clk_i,
	input logic        wb_rst_i,
	input logic        wbs_cyc_i,
	input logic        wbs_stb_i,
	input logic [31:0] wbs_adr_i,
	input logic        wbs_ack_o
);

	// ******************************
	// handshake shape
	// ******************************

	ack_needs_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wbs_ack_o |-> wbs_cyc_i && wbs_stb_i)
		else $error("ack high without cyc and stb");

	ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wbs_ack_o |=> !wbs_ack_o)
		else $error("ack held for more than one cycle");

	// first edge out of reset
	ack_low_after_reset: assert property (@(posedge wb_clk_i)
		$fell(wb_rst_i) |-> !wbs_ack_o)
		else $error("ack high right after reset release");

	// ******************************
	// ack latency
	// ******************************

	// page register goes through IDLE, READ/WRITE, FINISH
	page_ack_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wbs_ack_o && !wbs_adr_i[15] |-> $past(wbs_stb_i, 2) && !$past(wbs_stb_i, 3))
		else $error("page access ack not 2 edges after request");

	user_ack_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wbs_ack_o && wbs_adr_i[15] |-> $past(wbs_stb_i) && !$past(wbs_stb_i, 2))
		else $error("user access ack not 1 edge after request");	// slaves register once

endmodule

bind wb_ext_top wb_ext_assertions u_assertions (
	.wb_clk_i  (wb_clk_i),
	.wb_rst_i  (wb_rst_i),
	.wbs_cyc_i (wbs_cyc_i),
	.wbs_stb_i (wbs_stb_i),
	.wbs_adr_i (wbs_adr_i),
	.wbs_ack_o (wbs_ack_o)
);

//--- rtl/wb_ext_top.sv
module wb_ext_top import wb_ext_pkg::*; (
	input  logic        wb_clk_i,
	input  logic        wb_rst_i,
	input  logic        wbs_cyc_i,
	input  logic        wbs_stb_i,
	input  logic        wbs_we_i,
	input  logic [3:0]  wbs_sel_i,
	input  logic [31:0] wbs_adr_i,
	input  logic [31:0] wbs_dat_i,
	output logic        wbs_ack_o,
	output logic [31:0] wbs_dat_o
);

	wb_req_t host_req;
	wb_rsp_t host_rsp;
	wb_req_t user_req;
	wb_rsp_t user_rsp;
	wb_req_t sram_req;
	wb_rsp_t sram_rsp;
	wb_req_t regs_req;
	wb_rsp_t regs_rsp;

	assign host_req = '{
		cyc: wbs_cyc_i,
		stb: wbs_stb_i,
		we:  wbs_we_i,
		sel: wbs_sel_i,
		adr: wbs_adr_i,
		dat: wbs_dat_i
	};

	assign wbs_ack_o = host_rsp.ack;
	assign wbs_dat_o = host_rsp.dat;

	wb_addr_ext u_addr_ext (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.host_req_i (host_req),
		.host_rsp_o (host_rsp),
		.user_req_o (user_req),
		.user_rsp_i (user_rsp)
	);

	wb_user_decoder u_decoder (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.req_i      (user_req),
		.rsp_o      (user_rsp),
		.sram_req_o (sram_req),
		.regs_req_o (regs_req),
		.sram_rsp_i (sram_rsp),
		.regs_rsp_i (regs_rsp)
	);

	wb_sram_slave u_sram (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.req_i    (sram_req),
		.rsp_o    (sram_rsp)
	);

	wb_reg_bank u_regs (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.req_i    (regs_req),
		.rsp_o    (regs_rsp)
	);

endmodule

//--- rtl/wb_reg_bank.sv
`include "wb_ext_cfg.svh"

module wb_reg_bank import wb_ext_pkg::*; (
	input  logic    wb_clk_i,
	input  logic    wb_rst_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [31:0] ctrl_q [3];
	logic [1:0]  word_idx;
	logic        access;
	logic        ack_q;
	logic [31:0] rdata_q;

	assign word_idx = req_i.adr[3:2];	// upper bits alias
	assign access   = req_i.cyc && req_i.stb && !ack_q;

	// ******************************
	// control registers
	// ******************************

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			ack_q <= 1'b0;
			for (int w = 0; w < 3; w++) begin
				ctrl_q[w] <= 32'h0;
			end
		end else begin
			ack_q <= access;
			// word 3 has no storage, so writes to it fall through
			for (int w = 0; w < 3; w++) begin
				if (access && req_i.we && word_idx == 2'(w)) begin
					for (int b = 0; b < 4; b++) begin
						if (req_i.sel[b]) begin
							ctrl_q[w][8*b +: 8] <= req_i.dat[8*b +: 8];
						end
					end
				end
			end
		end
	end

	// ******************************
	// read path
	// ******************************

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			case (word_idx)
				2'd0:    rdata_q <= ctrl_q[0];
				2'd1:    rdata_q <= ctrl_q[1];
				2'd2:    rdata_q <= ctrl_q[2];
				default: rdata_q <= `WB_REG_ID;
			endcase
		end
	end

	assign rsp_o = '{ack: ack_q, dat: rdata_q};

endmodule

//--- rtl/wb_sram_slave.sv
`include "wb_ext_cfg.svh"

module wb_sram_slave import wb_ext_pkg::*; (
	input  logic    wb_clk_i,
	input  logic    wb_rst_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int ADDR_W = $clog2(`WB_SRAM_WORDS);

	logic [31:0]       mem [`WB_SRAM_WORDS];
	logic [ADDR_W-1:0] word_idx;
	logic              access;
	logic              ack_q;
	logic [31:0]       rdata_q;

	assign word_idx = req_i.adr[ADDR_W+1:2];	// byte address to word
	assign access   = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			rdata_q <= mem[word_idx];
			if (req_i.we) begin
				for (int i = 0; i < 4; i++) begin
					if (req_i.sel[i]) begin
						mem[word_idx][8*i +: 8] <= req_i.dat[8*i +: 8];
					end
				end
			end
		end
	end

	assign rsp_o = '{ack: ack_q, dat: rdata_q};

endmodule

//--- rtl/wb_user_decoder.sv
`include "wb_ext_cfg.svh"

module wb_user_decoder import wb_ext_pkg::*; (
	input  logic    wb_clk_i,
	input  logic    wb_rst_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o,
	output wb_req_t sram_req_o,
	output wb_req_t regs_req_o,
	input  wb_rsp_t sram_rsp_i,
	input  wb_rsp_t regs_rsp_i
);

	logic sram_hit;
	logic regs_hit;
	logic dflt_hit;
	logic dflt_ack_q;

	assign sram_hit = (req_i.adr[31:16] == `WB_SRAM_BASE);
	assign regs_hit = (req_i.adr[31:16] == `WB_REGS_BASE);
	assign dflt_hit = !sram_hit && !regs_hit;

	// only the matching slave sees cyc
	always_comb begin
		sram_req_o     = req_i;
		sram_req_o.cyc = req_i.cyc & sram_hit;
		regs_req_o     = req_i;
		regs_req_o.cyc = req_i.cyc & regs_hit;
	end

	// ******************************
	// default responder
	// ******************************

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			dflt_ack_q <= 1'b0;
		end else begin
			// writes are dropped, only the handshake completes
			dflt_ack_q <= req_i.cyc && req_i.stb && dflt_hit && !dflt_ack_q;
		end
	end

	// ******************************
	// response mux
	// ******************************

	always_comb begin
		if (sram_hit) begin
			rsp_o = sram_rsp_i;
		end else if (regs_hit) begin
			rsp_o = regs_rsp_i;
		end else begin
			rsp_o.ack = dflt_ack_q;
			rsp_o.dat = `WB_UNMAPPED_DATA;
		end
	end

endmodule

//--- rtl/wb_addr_ext.sv
`include "wb_ext_cfg.svh"

module wb_addr_ext import wb_ext_pkg::*; (
	input  logic    wb_clk_i,
	input  logic    wb_rst_i,
	input  wb_req_t host_req_i,
	output wb_rsp_t host_rsp_o,
	output wb_req_t user_req_o,
	input  wb_rsp_t user_rsp_i
);

	typedef enum logic [1:0] {
		ST_IDLE   = 2'h0,
		ST_WRITE  = 2'h1,
		ST_READ   = 2'h2,
		ST_FINISH = 2'h3
	} state_t;

	state_t                      state_q;
	logic [31:0]                 page_q;
	logic [31:0]                 rd_buf_q;
	logic                        ack_q;
	logic                        user_sel;
	logic [`WB_EXT_PAGE_BIT-1:0] offset;

	assign user_sel = host_req_i.adr[`WB_EXT_PAGE_BIT];
	assign offset   = host_req_i.adr[`WB_EXT_PAGE_BIT-1:0];

	// ******************************
	// user window
	// ******************************

	always_comb begin
		user_req_o     = host_req_i;	// stb, we, sel, dat pass through
		user_req_o.cyc = host_req_i.cyc & user_sel;
		user_req_o.adr = {page_q[31:`WB_EXT_PAGE_BIT], offset};
	end

	// ******************************
	// page register access
	// ******************************

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state_q  <= ST_IDLE;
			ack_q    <= 1'b0;
			page_q   <= 32'h0;
			rd_buf_q <= 32'h0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					ack_q    <= 1'b0;
					rd_buf_q <= 32'h0;
					if (host_req_i.cyc && host_req_i.stb && !user_sel) begin
						state_q <= host_req_i.we ? ST_WRITE : ST_READ;
					end
				end

				ST_WRITE: begin
					ack_q   <= 1'b1;
					state_q <= ST_FINISH;
					for (int i = 0; i < 4; i++) begin
						if (host_req_i.sel[i]) begin
							page_q[8*i +: 8] <= host_req_i.dat[8*i +: 8];
						end
					end
				end

				ST_READ: begin
					ack_q    <= 1'b1;
					rd_buf_q <= page_q;
					state_q  <= ST_FINISH;
				end

				ST_FINISH: begin
					ack_q   <= 1'b0;	// host still holds stb here
					state_q <= ST_IDLE;
				end

				default: begin
					ack_q   <= 1'b0;
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// response follows the host's current window
	always_comb begin
		if (user_sel) begin
			host_rsp_o = user_rsp_i;
		end else begin
			host_rsp_o.ack = ack_q;
			host_rsp_o.dat = rd_buf_q;
		end
	end

endmodule

//--- rtl/wb_ext_pkg.sv
package wb_ext_pkg;

	// one wishbone request as the master drives it
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	// slave response, dat only meaningful while ack is high
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

//--- rtl/wb_ext_cfg.svh
`ifndef WB_EXT_CFG_SVH
`define WB_EXT_CFG_SVH

// host address bit that selects user space
`define WB_EXT_PAGE_BIT 15

// decoder bases match extended address bits 31..16
`define WB_SRAM_BASE 16'h3000
`define WB_REGS_BASE 16'h3001

// sram depth in 32-bit words
`define WB_SRAM_WORDS 256

`define WB_REG_ID 32'h5741_4558	// read-only id word in the register bank

// read value for addresses nobody claims
`define WB_UNMAPPED_DATA 32'hbad0_bad0

`endif
